/* common/bcache_pkg.sv */
package bcache_pkg;

  localparam int dw = 32;
  localparam int lanes = 4;
  localparam int row_w = lanes * dw;

  // signed fixed point, 19 fraction bits
  localparam int frac_bits = 19;
  localparam logic signed [dw-1:0] fx_one = 32'sh0008_0000;

  // measurement noise diagonal
  localparam logic signed [dw-1:0] q_11 = fx_one;
  localparam logic signed [dw-1:0] q_22 = fx_one;

  localparam int seq_w = 4;
  localparam int depth = 64;
  localparam int addr_w = 6;

  // jacobian and noise entries, wr_base excluded
  localparam int n_jac = 18;

  typedef enum logic [3:0] {
    idle      = 4'b0000,
    transpose = 4'b1001,
    inv       = 4'b1010,
    chi       = 4'b1011,
    nl_prd    = 4'b1100,
    nl_assoc  = 4'b1101,
    nl_new    = 4'b1110,
    nl_upd    = 4'b1111
  } bca_mode_e;

  typedef enum logic [4:0] {
    fxi_13, fxi_23,
    gxi_13, gxi_23, gz_11, gz_12, gz_21, gz_22,
    hz_11, hz_12, hz_21, hz_22,
    hxi_11, hxi_12, hxi_21, hxi_22,
    vt_1, vt_2,
    wr_base
  } reg_idx_e;

  // rows written per operation
  function automatic logic [seq_w-1:0] mode_len(bca_mode_e m);
    case (m)
      nl_prd:    return 4'd5;
      nl_new:    return 4'd6;
      nl_upd:    return 4'd7;
      nl_assoc:  return 4'd8;
      transpose: return 4'd4;
      inv:       return 4'd11;
      chi:       return 4'd11;
      default:   return 4'd0;
    endcase
  endfunction

endpackage

/* logic/seq_counter.sv */
`timescale 1ns/100ps

module seq_counter (
  input  logic                           clk,
  input  logic                           sys_rst,
  input  logic                           start,
  input  bcache_pkg::bca_mode_e          mode,
  output bcache_pkg::bca_mode_e          mode_q,
  output logic [bcache_pkg::seq_w-1:0]   seq_cnt,
  output logic                           busy,
  output logic                           done
);
  import bcache_pkg::*;

  logic [seq_w-1:0] len_q;
  logic [seq_w-1:0] start_len;

  assign start_len = mode_len(mode);
  assign busy = (seq_cnt != '0);

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      mode_q  <= idle;
      len_q   <= '0;
      seq_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        // idle has no steps, so a start with it does nothing
        if (start && start_len != '0) begin
          mode_q  <= mode;
          len_q   <= start_len;
          seq_cnt <= 4'd1;
        end
      end else if (seq_cnt == len_q) begin
        // lines up with the mapper's last write
        seq_cnt <= '0;
        done    <= 1'b1;
      end else begin
        seq_cnt <= seq_cnt + 1'b1;
      end
    end
  end

endmodule

/* logic/jacobian_regs.sv */
`timescale 1ns/100ps

module jacobian_regs (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  logic                            cfg_we,
  input  bcache_pkg::reg_idx_e            cfg_idx,
  input  logic [bcache_pkg::dw-1:0]       cfg_wdata,
  output logic [bcache_pkg::dw-1:0]       fxi_13, fxi_23,
  output logic [bcache_pkg::dw-1:0]       gxi_13, gxi_23,
  output logic [bcache_pkg::dw-1:0]       gz_11, gz_12, gz_21, gz_22,
  output logic [bcache_pkg::dw-1:0]       hz_11, hz_12, hz_21, hz_22,
  output logic [bcache_pkg::dw-1:0]       hxi_11, hxi_12, hxi_21, hxi_22,
  output logic [bcache_pkg::dw-1:0]       vt_1, vt_2,
  output logic [bcache_pkg::addr_w-1:0]   wr_base
);
  import bcache_pkg::*;

  logic [dw-1:0] jac_q [n_jac];

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int i = 0; i < n_jac; i++) begin
        jac_q[i] <= '0;
      end
      wr_base <= '0;
    end else if (cfg_we) begin
      // base address keeps only the low bits
      if (cfg_idx == bcache_pkg::wr_base) begin
        wr_base <= cfg_wdata[addr_w-1:0];
      end else begin
        jac_q[cfg_idx] <= cfg_wdata;
      end
    end
  end

  assign fxi_13 = jac_q[bcache_pkg::fxi_13];
  assign fxi_23 = jac_q[bcache_pkg::fxi_23];
  assign gxi_13 = jac_q[bcache_pkg::gxi_13];
  assign gxi_23 = jac_q[bcache_pkg::gxi_23];
  assign gz_11  = jac_q[bcache_pkg::gz_11];
  assign gz_12  = jac_q[bcache_pkg::gz_12];
  assign gz_21  = jac_q[bcache_pkg::gz_21];
  assign gz_22  = jac_q[bcache_pkg::gz_22];
  assign hz_11  = jac_q[bcache_pkg::hz_11];
  assign hz_12  = jac_q[bcache_pkg::hz_12];
  assign hz_21  = jac_q[bcache_pkg::hz_21];
  assign hz_22  = jac_q[bcache_pkg::hz_22];
  assign hxi_11 = jac_q[bcache_pkg::hxi_11];
  assign hxi_12 = jac_q[bcache_pkg::hxi_12];
  assign hxi_21 = jac_q[bcache_pkg::hxi_21];
  assign hxi_22 = jac_q[bcache_pkg::hxi_22];
  assign vt_1   = jac_q[bcache_pkg::vt_1];
  assign vt_2   = jac_q[bcache_pkg::vt_2];

endmodule

/* b_cache/b_cache_din_map.sv */
`timescale 1ns/100ps

module b_cache_din_map (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  bcache_pkg::bca_mode_e           mode_q,
  input  logic [bcache_pkg::seq_w-1:0]    seq_cnt,
  input  logic [bcache_pkg::dw-1:0]       fxi_13, fxi_23,
  input  logic [bcache_pkg::dw-1:0]       gxi_13, gxi_23,
  input  logic [bcache_pkg::dw-1:0]       gz_11, gz_12, gz_21, gz_22,
  input  logic [bcache_pkg::dw-1:0]       hz_11, hz_12, hz_21, hz_22,
  input  logic [bcache_pkg::dw-1:0]       hxi_11, hxi_12, hxi_21, hxi_22,
  input  logic [bcache_pkg::dw-1:0]       vt_1, vt_2,
  input  logic [bcache_pkg::addr_w-1:0]   wr_base,
  input  logic [bcache_pkg::row_w-1:0]    tb_rdata,
  input  logic [bcache_pkg::row_w-1:0]    c_din,
  output logic                            wr_en,
  output logic [bcache_pkg::addr_w-1:0]   wr_addr,
  output logic [bcache_pkg::row_w-1:0]    wr_row
);
  import bcache_pkg::*;

  // full product, rescaled back to frac_bits
  function automatic logic signed [dw-1:0] fx_mul(
    input logic signed [dw-1:0] a,
    input logic signed [dw-1:0] b
  );
    logic signed [2*dw-1:0] prod;
    prod = a * b;
    return dw'(prod >>> frac_bits);
  endfunction

  logic signed [dw-1:0] c_lo;
  logic signed [dw-1:0] c_hi;
  logic [lanes-1:0][dw-1:0] row_d;

  // inverse working values
  logic signed [dw-1:0] s11;
  logic signed [dw-1:0] s12;
  logic signed [dw-1:0] s22;
  logic signed [dw-1:0] prod_p;
  logic signed [dw-1:0] prod_m;
  logic signed [dw-1:0] det;

  assign c_lo = c_din[0 +: dw];
  assign c_hi = c_din[dw +: dw];

  always_comb begin
    row_d = '0;
    case (mode_q)
      nl_prd: begin
        case (seq_cnt)
          1: row_d[0] = fx_one;
          3: begin
            row_d[0] = fxi_13;
            row_d[1] = fx_one;
          end
          4: row_d[1] = fxi_23;
          5: row_d[2] = fx_one;
          default: ;
        endcase
      end
      nl_new: begin
        case (seq_cnt)
          1: row_d[0] = fx_one;
          3: begin
            row_d[0] = gxi_13;
            row_d[1] = fx_one;
          end
          4: begin
            row_d[0] = gz_11;
            row_d[1] = gxi_23;
          end
          5: begin
            row_d[0] = gz_12;
            row_d[1] = gz_21;
          end
          6: row_d[1] = gz_22;
          default: ;
        endcase
      end
      // update and association share the first five rows
      nl_upd, nl_assoc: begin
        case (seq_cnt)
          1: row_d[0] = hxi_11;
          2: begin
            row_d[0] = hxi_12;
            row_d[1] = hxi_21;
          end
          3: row_d[1] = hxi_22;
          4: begin
            row_d[0] = hz_11;
            row_d[1] = -fx_one;
          end
          5: begin
            row_d[0] = hz_12;
            row_d[1] = hz_21;
          end
          6: begin
            row_d[0] = (mode_q == nl_upd) ? vt_1 : fx_one;
            row_d[1] = hz_22;
          end
          7: if (mode_q == nl_upd) row_d[0] = vt_2;
          8: if (mode_q == nl_assoc) row_d[1] = fx_one;
          default: ;
        endcase
      end
      transpose: row_d = tb_rdata;
      inv: begin
        // adjugate then determinant, division is done downstream
        case (seq_cnt)
          8: row_d[0] = s22;
          9: begin
            row_d[0] = -s12;
            row_d[1] = -s12;
          end
          10: row_d[1] = s11;
          11: row_d[0] = det;
          default: ;
        endcase
      end
      chi: begin
        if (seq_cnt == 4'd10 || seq_cnt == 4'd11) row_d[0] = c_lo;
      end
      default: ;
    endcase
  end

  // S = C + Q and its determinant, built over steps 3 to 7
  always_ff @(posedge clk) begin
    if (mode_q == inv) begin
      case (seq_cnt)
        3: s11 <= c_lo + q_11;
        4: begin
          s12    <= c_lo;
          prod_p <= fx_mul(c_lo, c_hi);
        end
        5: s22 <= c_hi + q_22;
        6: prod_m <= fx_mul(s11, s22);
        7: det <= prod_m - prod_p;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_en   <= 1'b0;
      wr_addr <= '0;
      wr_row  <= '0;
    end else begin
      wr_en   <= (seq_cnt != '0);
      wr_addr <= wr_base + addr_w'(seq_cnt) - addr_w'(1);
      wr_row  <= row_d;
    end
  end

endmodule

/* b_cache/b_cache_ram.sv */
`timescale 1ns/100ps

module b_cache_ram (
  input  logic                            clk,
  input  logic                            wr_en,
  input  logic [bcache_pkg::addr_w-1:0]   wr_addr,
  input  logic [bcache_pkg::row_w-1:0]    wr_row,
  input  logic [bcache_pkg::addr_w-1:0]   rd_addr,
  output logic [bcache_pkg::row_w-1:0]    rd_data
);
  import bcache_pkg::*;

  logic [row_w-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_row;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* logic/b_cache_top.sv */
`timescale 1ns/100ps

module b_cache_top (
  input  logic                            clk,
  input  logic                            sys_rst,
  input  logic                            start,
  input  bcache_pkg::bca_mode_e           mode,
  input  logic                            cfg_we,
  input  bcache_pkg::reg_idx_e            cfg_idx,
  input  logic [bcache_pkg::dw-1:0]       cfg_wdata,
  input  logic [bcache_pkg::row_w-1:0]    tb_rdata,
  input  logic [bcache_pkg::row_w-1:0]    c_din,
  input  logic [bcache_pkg::addr_w-1:0]   rd_addr,
  output logic [bcache_pkg::row_w-1:0]    rd_data,
  output logic [bcache_pkg::seq_w-1:0]    seq_cnt,
  output logic                            busy,
  output logic                            done
);
  import bcache_pkg::*;

  bca_mode_e mode_q;

  logic [dw-1:0] fxi_13, fxi_23;
  logic [dw-1:0] gxi_13, gxi_23, gz_11, gz_12, gz_21, gz_22;
  logic [dw-1:0] hz_11, hz_12, hz_21, hz_22;
  logic [dw-1:0] hxi_11, hxi_12, hxi_21, hxi_22;
  logic [dw-1:0] vt_1, vt_2;
  logic [addr_w-1:0] wr_base;

  logic              wr_en;
  logic [addr_w-1:0] wr_addr;
  logic [row_w-1:0]  wr_row;

  seq_counter seq_counter_i (
    .clk, .sys_rst, .start, .mode,
    .mode_q, .seq_cnt, .busy, .done
  );

  jacobian_regs jacobian_regs_i (
    .clk, .sys_rst, .cfg_we, .cfg_idx, .cfg_wdata,
    .fxi_13, .fxi_23,
    .gxi_13, .gxi_23, .gz_11, .gz_12, .gz_21, .gz_22,
    .hz_11, .hz_12, .hz_21, .hz_22,
    .hxi_11, .hxi_12, .hxi_21, .hxi_22,
    .vt_1, .vt_2,
    .wr_base
  );

  b_cache_din_map b_cache_din_map_i (
    .clk, .sys_rst, .mode_q, .seq_cnt,
    .fxi_13, .fxi_23,
    .gxi_13, .gxi_23, .gz_11, .gz_12, .gz_21, .gz_22,
    .hz_11, .hz_12, .hz_21, .hz_22,
    .hxi_11, .hxi_12, .hxi_21, .hxi_22,
    .vt_1, .vt_2,
    .wr_base, .tb_rdata, .c_din,
    .wr_en, .wr_addr, .wr_row
  );

  b_cache_ram b_cache_ram_i (
    .clk, .wr_en, .wr_addr, .wr_row,
    .rd_addr, .rd_data
  );

endmodule

/* bench/tb_b_cache.sv */
`timescale 1ns/100ps

module tb_b_cache;
  import bcache_pkg::*;

  // the directed tests take under 300 cycles
  localparam int max_cycles = 2000;
  localparam logic [dw-1:0] one_fx = 32'h0008_0000;

  logic              clk;
  logic              sys_rst;
  logic              start;
  bca_mode_e         mode;
  logic              cfg_we;
  reg_idx_e          cfg_idx;
  logic [dw-1:0]     cfg_wdata;
  logic [row_w-1:0]  tb_rdata;
  logic [row_w-1:0]  c_din;
  logic [addr_w-1:0] rd_addr;
  logic [row_w-1:0]  rd_data;
  logic [seq_w-1:0]  seq_cnt;
  logic              busy;
  logic              done;

  // model of the register bank plus per-step stimulus and expected rows
  logic [dw-1:0]    reg_val [19];
  logic [row_w-1:0] c_rows [1:11];
  logic [row_w-1:0] t_rows [1:11];
  logic [row_w-1:0] exp_rows [1:11];
  int cycles = 0;

  b_cache_top b_cache_top_i (
    .clk, .sys_rst, .start, .mode,
    .cfg_we, .cfg_idx, .cfg_wdata,
    .tb_rdata, .c_din, .rd_addr,
    .rd_data, .seq_cnt, .busy, .done
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check(input logic [row_w-1:0] got, input logic [row_w-1:0] exp,
                       input string msg);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [dw-1:0] fixed_mult(input logic [dw-1:0] a, input logic [dw-1:0] b);
    longint prod;
    prod = longint'($signed(a)) * longint'($signed(b));
    return dw'(prod >>> frac_bits);
  endfunction

  // signed value within about +-4.0
  function automatic logic [dw-1:0] small_fx();
    return $urandom_range(32'h0040_0000) - 32'h0020_0000;
  endfunction

  function automatic logic [row_w-1:0] rand_row();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // lane table of the constant modes
  function automatic logic [row_w-1:0] expected_const(input bca_mode_e m, input int s);
    logic [lanes-1:0][dw-1:0] r;
    r = '0;
    case (m)
      nl_prd: begin
        if (s == 1) r[0] = one_fx;
        if (s == 3) r = {64'd0, one_fx, reg_val[fxi_13]};
        if (s == 4) r[1] = reg_val[fxi_23];
        if (s == 5) r[2] = one_fx;
      end
      nl_new: begin
        if (s == 1) r[0] = one_fx;
        if (s == 3) r = {64'd0, one_fx, reg_val[gxi_13]};
        if (s == 4) r = {64'd0, reg_val[gxi_23], reg_val[gz_11]};
        if (s == 5) r = {64'd0, reg_val[gz_21], reg_val[gz_12]};
        if (s == 6) r[1] = reg_val[gz_22];
      end
      nl_upd, nl_assoc: begin
        if (s == 1) r[0] = reg_val[hxi_11];
        if (s == 2) r = {64'd0, reg_val[hxi_21], reg_val[hxi_12]};
        if (s == 3) r[1] = reg_val[hxi_22];
        if (s == 4) r = {64'd0, -one_fx, reg_val[hz_11]};
        if (s == 5) r = {64'd0, reg_val[hz_21], reg_val[hz_12]};
        if (m == nl_upd) begin
          if (s == 6) r = {64'd0, reg_val[hz_22], reg_val[vt_1]};
          if (s == 7) r[0] = reg_val[vt_2];
        end else begin
          if (s == 6) r = {64'd0, reg_val[hz_22], one_fx};
          if (s == 8) r[1] = one_fx;
        end
      end
      default: ;
    endcase
    return r;
  endfunction

  task automatic write_reg(input reg_idx_e idx, input logic [dw-1:0] val);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_idx   <= idx;
    cfg_wdata <= val;
    @(posedge clk);
    cfg_we <= 1'b0;
    reg_val[idx] = val;
  endtask

  task automatic read_row(input logic [addr_w-1:0] addr, output logic [row_w-1:0] row);
    @(posedge clk);
    rd_addr <= addr;
    @(posedge clk);
    @(negedge clk);
    row = rd_data;
  endtask

  // poke_step > 0 raises start again while that step is shown
  task automatic run_mode(input bca_mode_e m, input int len, input int poke_step);
    int j;
    j = 0;
    @(posedge clk);
    start <= 1'b1;
    mode  <= m;
    do begin
      @(posedge clk);
      j++;
      start <= (j == poke_step);
      if (j == poke_step) mode <= chi;
      // seq_cnt shows step j in the coming cycle
      if (j <= len) begin
        c_din    <= c_rows[j];
        tb_rdata <= t_rows[j];
      end
      @(negedge clk);
      if (!done) begin
        check(seq_cnt, j, $sformatf("%s seq_cnt", m.name()));
        check(busy, 1, $sformatf("%s busy at step %0d", m.name(), j));
      end
    end while (!done);
    check(j, len + 1, $sformatf("%s cycles from start to done", m.name()));
    check(seq_cnt, 0, "seq_cnt with done");
    check(busy, 0, "busy with done");
  endtask

  task automatic verify_rows(input int base, input int n, input string tag);
    logic [row_w-1:0] row;
    for (int k = 1; k <= n; k++) begin
      read_row(addr_w'(base + k - 1), row);
      check(row, exp_rows[k], $sformatf("%s row %0d", tag, k));
    end
  endtask

  task automatic quiet_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      check(done, 0, "extra done pulse");
      check(busy, 0, "busy after done");
    end
  endtask

  task automatic run_const_mode(input bca_mode_e m, input int len, input int base);
    write_reg(wr_base, dw'(base));
    for (int k = 1; k <= 11; k++) begin
      c_rows[k]   = rand_row();
      t_rows[k]   = rand_row();
      exp_rows[k] = expected_const(m, k);
    end
    run_mode(m, len, 0);
    verify_rows(base, len, m.name());
  endtask

  task automatic idle_after_reset();
    @(negedge clk);
    check(busy, 0, "busy after reset");
    check(done, 0, "done after reset");
    check(seq_cnt, 0, "seq_cnt after reset");
  endtask

  task automatic constant_modes();
    for (int i = 0; i < 18; i++) begin
      write_reg(reg_idx_e'(i), $urandom());
    end
    run_const_mode(nl_prd, 5, 0);
    run_const_mode(nl_new, 6, 8);
    run_const_mode(nl_upd, 7, 16);
    run_const_mode(nl_assoc, 8, 24);
  endtask

  task automatic transpose_copy();
    write_reg(wr_base, 32);
    for (int k = 1; k <= 11; k++) begin
      c_rows[k]   = rand_row();
      t_rows[k]   = rand_row();
      exp_rows[k] = t_rows[k];
    end
    run_mode(transpose, 4, 0);
    verify_rows(32, 4, "transpose");
  endtask

  task automatic inverse_rows();
    logic [dw-1:0] s11;
    logic [dw-1:0] s12;
    logic [dw-1:0] s22;
    logic [dw-1:0] det;
    write_reg(wr_base, 40);
    for (int k = 1; k <= 11; k++) begin
      c_rows[k]   = rand_row();
      t_rows[k]   = rand_row();
      exp_rows[k] = '0;
    end
    for (int k = 3; k <= 5; k++) begin
      c_rows[k][0 +: dw]  = small_fx();
      c_rows[k][dw +: dw] = small_fx();
    end
    // S = C + Q with its adjugate and determinant
    s11 = c_rows[3][0 +: dw] + one_fx;
    s12 = c_rows[4][0 +: dw];
    s22 = c_rows[5][dw +: dw] + one_fx;
    det = fixed_mult(s11, s22) - fixed_mult(c_rows[4][0 +: dw], c_rows[4][dw +: dw]);
    exp_rows[8]  = {64'd0, 32'd0, s22};
    exp_rows[9]  = {64'd0, -s12, -s12};
    exp_rows[10] = {64'd0, s11, 32'd0};
    exp_rows[11] = {96'd0, det};
    run_mode(inv, 11, 0);
    verify_rows(40, 11, "inv");
  endtask

  task automatic chi_rows();
    write_reg(wr_base, 52);
    for (int k = 1; k <= 11; k++) begin
      c_rows[k]   = rand_row();
      t_rows[k]   = rand_row();
      exp_rows[k] = (k >= 10) ? {96'd0, c_rows[k][0 +: dw]} : '0;
    end
    run_mode(chi, 11, 0);
    verify_rows(52, 11, "chi");
  endtask

  task automatic start_while_busy();
    write_reg(wr_base, 56);
    for (int k = 1; k <= 11; k++) begin
      c_rows[k]   = rand_row();
      t_rows[k]   = rand_row();
      exp_rows[k] = expected_const(nl_prd, k);
    end
    run_mode(nl_prd, 5, 2);
    // long enough for a chi run to have shown up
    quiet_cycles(14);
    verify_rows(56, 5, "prd with second start");
  endtask

  initial begin
    void'($urandom(32'hc184_3e72));
    sys_rst   = 1'b1;
    start     = 1'b0;
    mode      = idle;
    cfg_we    = 1'b0;
    cfg_idx   = fxi_13;
    cfg_wdata = '0;
    tb_rdata  = '0;
    c_din     = '0;
    rd_addr   = '0;
    repeat (16) @(posedge clk);
    sys_rst <= 1'b0;
    idle_after_reset();
    constant_modes();
    transpose_copy();
    inverse_rows();
    chi_rows();
    start_while_busy();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* project.f */
common/bcache_pkg.sv
logic/seq_counter.sv
logic/jacobian_regs.sv
b_cache/b_cache_din_map.sv
b_cache/b_cache_ram.sv
logic/b_cache_top.sv
bench/tb_b_cache.sv

/* run.sh */
#!/bin/sh
# build and run the B-cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_b_cache -f project.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
